/* Bender.yml */
package:
  name: greenhouse

sources:
  - files:
      - src/greenhouse_pkg.sv
      - src/uart_rx.sv
      - src/sensor_frame.sv
      - src/climate_ctrl.sv
      - src/sun_tracker.sv
      - src/seg_display.sv
      - src/greenhouse_top.sv
  - target: test
    files:
      - test/tb_greenhouse.sv

/* greenhouse.f */
src/greenhouse_pkg.sv
src/uart_rx.sv
src/sensor_frame.sv
src/climate_ctrl.sv
src/sun_tracker.sv
src/seg_display.sv
src/greenhouse_top.sv
test/tb_greenhouse.sv

/* src/climate_ctrl.sv */
`timescale 1ns/1ps

module climate_ctrl import greenhouse_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  sensor_t  sensor,
	input  logic     frame_valid,
	output climate_t climate
);

	temp_t gh;
	temp_t solar;
	temp_t geo;

	assign gh = sensor.gh_temp;
	assign solar = sensor.solar_temp;
	assign geo = sensor.geo_temp;

	// set wins over clear, otherwise hold.
	function automatic logic hyst(input logic cur, input logic set_c, input logic clr_c);
		if (set_c) return 1'b1;
		if (clr_c) return 1'b0;
		return cur;
	endfunction

	////////////////////////////////////////////////////////////
	// actuator update per frame.
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			climate <= '0;
		end else if (frame_valid) begin
			climate.window_open <= hyst(climate.window_open,
				gh >= WINDOW_ON, gh <= WINDOW_OFF);
			climate.fan_on <= hyst(climate.fan_on,
				gh >= FAN_ON, gh <= FAN_OFF);
			// heaters need a source warmer than the air.
			climate.geothermal_on <= hyst(climate.geothermal_on,
				gh <= HEAT_ON && geo > gh,
				gh >= HEAT_OFF || geo <= gh);
			climate.solarheater_on <= hyst(climate.solarheater_on,
				gh <= HEAT_ON && solar > gh,
				gh >= HEAT_OFF || solar <= gh);
		end
	end

endmodule

/* src/greenhouse_pkg.sv */
package greenhouse_pkg;

	typedef logic signed [7:0] temp_t;  // whole degrees celsius.
	typedef logic [7:0] light_t;
	typedef logic [6:0] seg_t;          // segment a in bit 0.
	typedef logic [3:0] anode_t;        // digit 0 is rightmost.

	typedef struct packed {
		temp_t gh_temp;
		temp_t solar_temp;
		temp_t geo_temp;
		light_t light_n;
		light_t light_e;
		light_t light_s;
		light_t light_w;
	} sensor_t;

	typedef struct packed {
		logic window_open;
		logic fan_on;
		logic geothermal_on;
		logic solarheater_on;
	} climate_t;

	typedef struct packed {
		logic north;
		logic east;
		logic south;
		logic west;
	} move_t;

	typedef enum logic {frame_hunt, frame_data} frame_state_t;
	typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

	////////////////////////////////////////////////////////////
	// climate thresholds.
	////////////////////////////////////////////////////////////
	localparam logic [7:0] FRAME_SYNC = 8'hA5;
	localparam temp_t WINDOW_ON = 8'sd28;
	localparam temp_t WINDOW_OFF = 8'sd26;
	localparam temp_t FAN_ON = 8'sd32;
	localparam temp_t FAN_OFF = 8'sd30;
	localparam temp_t HEAT_ON = 8'sd18;   // heaters may start at or below this.
	localparam temp_t HEAT_OFF = 8'sd20;
	localparam light_t TRACK_DEADBAND = 8'd8;

endpackage

/* src/greenhouse_top.sv */
`timescale 1ns/1ps

module greenhouse_top import greenhouse_pkg::*; #(
	parameter int CLKS_PER_BIT = 16,
	parameter int SCAN_DIV = 64
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   rx,
	output logic   tx,
	output logic   window_open,
	output logic   fan_on,
	output logic   geothermal_on,
	output logic   solarheater_on,
	output logic   move_north,
	output logic   move_east,
	output logic   move_south,
	output logic   move_west,
	output anode_t solar_anode_en,
	output anode_t greenhouse_anode_en,
	output anode_t geothermal_anode_en,
	output seg_t   solar_seg,
	output seg_t   greenhouse_seg,
	output seg_t   geothermal_seg
);

	logic [7:0] rx_byte;
	logic byte_valid;
	logic byte_error;
	logic frame_valid;
	sensor_t sensor;
	climate_t climate;
	move_t move;

	assign tx = 1'b1;  // no transmit side, line idle.
	assign window_open = climate.window_open;
	assign fan_on = climate.fan_on;
	assign geothermal_on = climate.geothermal_on;
	assign solarheater_on = climate.solarheater_on;
	assign move_north = move.north;
	assign move_east = move.east;
	assign move_south = move.south;
	assign move_west = move.west;

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
		.clk(clk), .reset(reset), .rx(rx),
		.rx_byte(rx_byte), .byte_valid(byte_valid), .byte_error(byte_error)
	);

	sensor_frame u_sensor_frame (
		.clk(clk), .reset(reset), .rx_byte(rx_byte), .byte_valid(byte_valid),
		.byte_error(byte_error), .sensor(sensor), .frame_valid(frame_valid)
	);

	climate_ctrl u_climate_ctrl (
		.clk(clk), .reset(reset), .sensor(sensor), .frame_valid(frame_valid),
		.climate(climate)
	);

	sun_tracker u_sun_tracker (
		.clk(clk), .reset(reset), .sensor(sensor), .frame_valid(frame_valid),
		.move(move)
	);

	////////////////////////////////////////////////////////////
	// temperature displays.
	////////////////////////////////////////////////////////////
	seg_display #(.SCAN_DIV(SCAN_DIV)) u_solar_disp (
		.clk(clk), .reset(reset), .temp(sensor.solar_temp), .frame_valid(frame_valid),
		.seg(solar_seg), .anode_en(solar_anode_en)
	);

	seg_display #(.SCAN_DIV(SCAN_DIV)) u_greenhouse_disp (
		.clk(clk), .reset(reset), .temp(sensor.gh_temp), .frame_valid(frame_valid),
		.seg(greenhouse_seg), .anode_en(greenhouse_anode_en)
	);

	seg_display #(.SCAN_DIV(SCAN_DIV)) u_geothermal_disp (
		.clk(clk), .reset(reset), .temp(sensor.geo_temp), .frame_valid(frame_valid),
		.seg(geothermal_seg), .anode_en(geothermal_anode_en)
	);

endmodule

/* src/seg_display.sv */
`timescale 1ns/1ps

module seg_display import greenhouse_pkg::*; #(
	parameter int SCAN_DIV = 64
) (
	input  logic   clk,
	input  logic   reset,
	input  temp_t  temp,
	input  logic   frame_valid,
	output seg_t   seg,
	output anode_t anode_en
);

	localparam int DIV_W = $clog2(SCAN_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCAN_DIV - 1);
	localparam seg_t SEG_MINUS = 7'h40;  // g only.
	localparam seg_t SEG_BLANK = 7'h00;

	temp_t temp_q;
	logic [7:0] mag;
	logic [DIV_W-1:0] div_cnt;

	function automatic seg_t hex_seg(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'h3F;
			4'h1: return 7'h06;
			4'h2: return 7'h5B;
			4'h3: return 7'h4F;
			4'h4: return 7'h66;
			4'h5: return 7'h6D;
			4'h6: return 7'h7D;
			4'h7: return 7'h07;
			4'h8: return 7'h7F;
			4'h9: return 7'h6F;
			4'hA: return 7'h77;
			4'hB: return 7'h7C;
			4'hC: return 7'h39;
			4'hD: return 7'h5E;
			4'hE: return 7'h79;
			default: return 7'h71;
		endcase
	endfunction

	assign mag = temp_q[7] ? -temp_q : temp_q;  // -128 gives 0x80.

	always_ff @(posedge clk) begin
		if (reset) begin
			temp_q <= '0;
			div_cnt <= '0;
			anode_en <= 4'b0001;
		end else begin
			if (frame_valid) temp_q <= temp;
			if (div_cnt == DIV_LAST) begin
				div_cnt <= '0;
				anode_en <= {anode_en[2:0], anode_en[3]};
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// digit select.
	////////////////////////////////////////////////////////////
	always_comb begin
		case (anode_en)
			4'b0001: seg = hex_seg(mag[3:0]);
			4'b0010: seg = hex_seg(mag[7:4]);
			4'b1000: seg = temp_q[7] ? SEG_MINUS : SEG_BLANK;
			default: seg = SEG_BLANK;  // digit 2 stays dark.
		endcase
	end

endmodule

/* src/sensor_frame.sv */
`timescale 1ns/1ps

module sensor_frame import greenhouse_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] rx_byte,
	input  logic       byte_valid,
	input  logic       byte_error,
	output sensor_t    sensor,
	output logic       frame_valid
);

	localparam logic [2:0] LAST_BYTE = 3'd6;
	localparam int REC_W = $bits(sensor_t);

	frame_state_t state;
	logic [2:0] byte_cnt;
	sensor_t shadow;
	sensor_t next_rec;
	logic take_byte;
	logic frame_done;

	// bytes shift in from the bottom, so gh ends up in the top field.
	assign next_rec = {shadow[REC_W-9:0], rx_byte};
	assign take_byte = (state == frame_data) && byte_valid;
	assign frame_done = take_byte && (byte_cnt == LAST_BYTE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= frame_hunt;
			byte_cnt <= '0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= frame_done;
			case (state)
				frame_hunt: begin
					byte_cnt <= '0;
					if (byte_valid && rx_byte == FRAME_SYNC) state <= frame_data;
				end
				frame_data: begin
					if (byte_error) begin
						state <= frame_hunt;  // drop partial frame.
					end else if (frame_done) begin
						state <= frame_hunt;
					end else if (take_byte) begin
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
				default: state <= frame_hunt;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// record assembly.
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (take_byte) shadow <= next_rec;
		if (frame_done) sensor <= next_rec;  // only whole frames.
	end

endmodule

/* src/sun_tracker.sv */
`timescale 1ns/1ps

module sun_tracker import greenhouse_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  sensor_t sensor,
	input  logic    frame_valid,
	output move_t   move
);

	// {toward a, toward b}; at most one bit set.
	function automatic logic [1:0] axis_move(input light_t a, input light_t b);
		logic [8:0] a_w;
		logic [8:0] b_w;
		logic [8:0] band;
		a_w = {1'b0, a};
		b_w = {1'b0, b};
		band = {1'b0, TRACK_DEADBAND};
		if (a_w > b_w + band) return 2'b10;
		if (b_w > a_w + band) return 2'b01;
		return 2'b00;  // inside deadband.
	endfunction

	////////////////////////////////////////////////////////////
	// per-frame move commands.
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			move <= '0;
		end else if (frame_valid) begin
			{move.north, move.south} <= axis_move(sensor.light_n, sensor.light_s);
			{move.east, move.west} <= axis_move(sensor.light_e, sensor.light_w);
		end
	end

endmodule

/* src/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import greenhouse_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       byte_valid,
	output logic       byte_error
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

	rx_state_t state;
	logic [2:0] rx_sync;  // two sync flops, then edge history.
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic rx_s;
	logic start_edge;

	assign rx_s = rx_sync[1];
	assign start_edge = rx_sync[2] & ~rx_sync[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_sync <= 3'b111;  // line idles high.
		end else begin
			rx_sync <= {rx_sync[1:0], rx};
		end
	end

	////////////////////////////////////////////////////////////
	// bit timing and framing.
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rx_idle;
			clk_cnt <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
			byte_error <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			byte_error <= 1'b0;
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (start_edge) state <= rx_start;
				end
				rx_start: begin
					if (clk_cnt == HALF_BIT) begin
						clk_cnt <= '0;
						state <= rx_s ? rx_idle : rx_data;  // reject glitches.
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_data: begin
					if (clk_cnt == FULL_BIT) begin
						clk_cnt <= '0;
						rx_byte <= {rx_s, rx_byte[7:1]};  // lsb first.
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) state <= rx_stop;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_stop: begin
					if (clk_cnt == FULL_BIT) begin
						byte_valid <= rx_s;
						byte_error <= ~rx_s;
						state <= rx_idle;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

endmodule

/* test/tb_greenhouse.sv */
`timescale 1ns/1ps

module tb_greenhouse import greenhouse_pkg::*; ();

	localparam int CLKS_PER_BIT = 16;
	localparam int SCAN_DIV = 8;
	localparam int NUM_FRAMES = 16;
	localparam int NUM_RANDOM = 6;
	localparam int SCAN_TIMEOUT = 16 * SCAN_DIV;
	// digits f down to 0.
	localparam logic [111:0] HEX_SEGS = {7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F,
		7'h7F, 7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F};

	typedef struct packed {
		sensor_t data;
		logic garbage;
		logic broken;  // third data byte gets a low stop bit.
	} entry_t;

	logic clk;
	logic reset;
	logic rx;
	logic tx, window_open, fan_on, geothermal_on, solarheater_on;
	logic move_north, move_east, move_south, move_west;
	anode_t solar_anode_en, greenhouse_anode_en, geothermal_anode_en;
	seg_t solar_seg, greenhouse_seg, geothermal_seg;

	entry_t frames [NUM_FRAMES];
	climate_t exp_clim;
	move_t exp_move;
	sensor_t last_good;
	int seed;
	int errs;
	int pass_cnt;
	int fail_cnt;

	greenhouse_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .SCAN_DIV(SCAN_DIV)) uut (
		.clk(clk), .reset(reset), .rx(rx), .tx(tx),
		.window_open(window_open), .fan_on(fan_on), .geothermal_on(geothermal_on),
		.solarheater_on(solarheater_on), .move_north(move_north), .move_east(move_east),
		.move_south(move_south), .move_west(move_west),
		.solar_anode_en(solar_anode_en), .greenhouse_anode_en(greenhouse_anode_en),
		.geothermal_anode_en(geothermal_anode_en), .solar_seg(solar_seg),
		.greenhouse_seg(greenhouse_seg), .geothermal_seg(geothermal_seg)
	);

	always #2 clk = ~clk;

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %0h expected %0h", $time, name, got, exp);
			errs++;
		end
	endtask

	task automatic send_bit(input logic v);
		@(posedge clk);
		rx <= v;
		repeat (CLKS_PER_BIT - 1) @(posedge clk);
	endtask

	task automatic send_byte(input logic [7:0] b, input logic bad_stop);
		send_bit(1'b0);
		for (int i = 0; i < 8; i++) send_bit(b[i]);  // lsb first.
		send_bit(~bad_stop);
		send_bit(1'b1);  // idle gap.
	endtask

	////////////////////////////////////////////////////////////
	// reference model.
	////////////////////////////////////////////////////////////
	task automatic update_model(input sensor_t s);
		int gh;
		int solar;
		int geo;
		int band;
		gh = s.gh_temp;
		solar = s.solar_temp;
		geo = s.geo_temp;
		band = TRACK_DEADBAND;
		if (gh >= WINDOW_ON) exp_clim.window_open = 1'b1;
		else if (gh <= WINDOW_OFF) exp_clim.window_open = 1'b0;
		if (gh >= FAN_ON) exp_clim.fan_on = 1'b1;
		else if (gh <= FAN_OFF) exp_clim.fan_on = 1'b0;
		if (gh <= HEAT_ON && geo > gh) exp_clim.geothermal_on = 1'b1;
		else if (gh >= HEAT_OFF || geo <= gh) exp_clim.geothermal_on = 1'b0;
		if (gh <= HEAT_ON && solar > gh) exp_clim.solarheater_on = 1'b1;
		else if (gh >= HEAT_OFF || solar <= gh) exp_clim.solarheater_on = 1'b0;
		exp_move.north = int'(s.light_n) - int'(s.light_s) > band;
		exp_move.south = int'(s.light_s) - int'(s.light_n) > band;
		exp_move.east = int'(s.light_e) - int'(s.light_w) > band;
		exp_move.west = int'(s.light_w) - int'(s.light_e) > band;
		last_good = s;
	endtask

	task automatic run_frame(input entry_t ent);
		if (ent.garbage) begin
			send_byte(8'h3C, 1'b0);
			send_byte(8'h00, 1'b0);
			send_byte(8'h5A, 1'b0);
		end
		send_byte(FRAME_SYNC, 1'b0);
		for (int i = 0; i < 7; i++) send_byte(ent.data[55 - 8 * i -: 8], ent.broken && i == 2);
		for (int n = 0; n < 4 * CLKS_PER_BIT; n++) @(posedge clk);  // settle margin.
		if (!ent.broken) update_model(ent.data);
	endtask

	task automatic check_outputs();
		@(negedge clk);
		check_val("tx", tx, 1'b1);
		check_val("window_open", window_open, exp_clim.window_open);
		check_val("fan_on", fan_on, exp_clim.fan_on);
		check_val("geothermal_on", geothermal_on, exp_clim.geothermal_on);
		check_val("solarheater_on", solarheater_on, exp_clim.solarheater_on);
		check_val("move_north", move_north, exp_move.north);
		check_val("move_east", move_east, exp_move.east);
		check_val("move_south", move_south, exp_move.south);
		check_val("move_west", move_west, exp_move.west);
		if ((move_north && move_south) || (move_east && move_west)) begin
			$display("opposite tracker moves are both high at t=%0t", $time);
			errs++;
		end
	endtask

	function automatic anode_t get_anode(input int which);
		if (which == 0) return solar_anode_en;
		if (which == 1) return greenhouse_anode_en;
		return geothermal_anode_en;
	endfunction

	function automatic seg_t get_seg(input int which);
		if (which == 0) return solar_seg;
		if (which == 1) return greenhouse_seg;
		return geothermal_seg;
	endfunction

	task automatic check_display(input int which, input temp_t t, input string name);
		logic [7:0] mag;
		seg_t exp;
		anode_t an;
		int n;
		mag = (t < 0) ? 8'(-t) : 8'(t);
		for (int d = 0; d < 4; d++) begin
			n = 0;
			an = get_anode(which);
			while (!an[d] && n < SCAN_TIMEOUT) begin
				@(negedge clk);
				an = get_anode(which);
				n++;
			end
			if (!an[d]) begin
				$display("%s display never enabled digit %0d", name, d);
				errs++;
			end else begin
				check_val({name, "_anode_en"}, an, 8'(1 << d));  // one digit at a time.
				case (d)
					0: exp = HEX_SEGS[mag[3:0] * 7 +: 7];
					1: exp = HEX_SEGS[mag[7:4] * 7 +: 7];
					2: exp = 7'h00;
					default: exp = (t < 0) ? 7'h40 : 7'h00;  // minus is g only.
				endcase
				check_val({name, "_seg"}, get_seg(which), exp);
			end
		end
	endtask

	task automatic check_displays();
		check_display(0, last_good.solar_temp, "solar");
		check_display(1, last_good.gh_temp, "greenhouse");
		check_display(2, last_good.geo_temp, "geothermal");
	endtask

	task automatic finish_test(input string label);
		if (errs == 0) begin
			pass_cnt++;
			$display("ok   %s", label);
		end else begin
			fail_cnt++;
			$display("bad  %s, %0d errors", label, errs);
		end
		errs = 0;
	endtask

	initial begin
		sensor_t s;
		clk = 1'b0;
		reset = 1'b1;
		rx = 1'b1;
		seed = 32'h3add;
		errs = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		exp_clim = '0;
		exp_move = '0;
		last_good = '0;
		// gh, solar, geo, n, e, s, w, garbage, broken.
		frames[0] = {8'd22, 8'd25, 8'd15, 8'd50, 8'd50, 8'd50, 8'd50, 1'b0, 1'b0};
		frames[1] = {8'd27, 8'd25, 8'd15, 8'd50, 8'd50, 8'd50, 8'd50, 1'b0, 1'b0};
		frames[2] = {8'd28, 8'd25, 8'd15, 8'd50, 8'd50, 8'd50, 8'd50, 1'b0, 1'b0};
		frames[3] = {8'd31, 8'd25, 8'd15, 8'd50, 8'd50, 8'd50, 8'd50, 1'b0, 1'b0};
		frames[4] = {8'd33, 8'd25, 8'd15, 8'd50, 8'd50, 8'd50, 8'd50, 1'b0, 1'b0};
		frames[5] = {8'd31, 8'd25, 8'd15, 8'd50, 8'd50, 8'd50, 8'd50, 1'b0, 1'b0};
		frames[6] = {8'd30, 8'd25, 8'd15, 8'd50, 8'd50, 8'd50, 8'd50, 1'b0, 1'b0};
		frames[7] = {8'd27, 8'd25, 8'd15, 8'd50, 8'd50, 8'd50, 8'd50, 1'b0, 1'b0};
		frames[8] = {8'd26, 8'd25, 8'd15, 8'd50, 8'd50, 8'd50, 8'd50, 1'b0, 1'b0};
		frames[9] = {8'd18, 8'd25, 8'd12, 8'd50, 8'd50, 8'd50, 8'd50, 1'b1, 1'b0};
		frames[10] = {8'd15, 8'd10, 8'd17, 8'd50, 8'd50, 8'd50, 8'd50, 1'b0, 1'b0};
		frames[11] = {8'd19, 8'd30, 8'd25, 8'd50, 8'd50, 8'd50, 8'd50, 1'b0, 1'b0};
		frames[12] = {8'd35, 8'd40, 8'd40, 8'd90, 8'd10, 8'd10, 8'd90, 1'b0, 1'b1};
		frames[13] = {8'hFB, 8'hFE, 8'hFD, 8'd200, 8'd30, 8'd20, 8'd100, 1'b0, 1'b0};
		frames[14] = {8'd20, 8'd25, 8'd25, 8'd10, 8'd120, 8'd18, 8'd100, 1'b1, 1'b0};
		frames[15] = {8'hEC, 8'd5, 8'hE2, 8'd40, 8'd60, 8'd49, 8'd60, 1'b0, 1'b0};
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		check_outputs();
		check_displays();
		finish_test("reset state");

		for (int i = 0; i < NUM_FRAMES; i++) begin
			run_frame(frames[i]);
			check_outputs();
			check_displays();
			finish_test($sformatf("frame %0d", i));
		end

		////////////////////////////////////////////////////////////
		// random light levels.
		////////////////////////////////////////////////////////////
		for (int r = 0; r < NUM_RANDOM; r++) begin
			s.gh_temp = 8'sd24;
			s.solar_temp = 8'sd20;
			s.geo_temp = 8'sd20;
			s.light_n = $random(seed);
			s.light_e = $random(seed);
			s.light_s = $random(seed);
			s.light_w = $random(seed);
			run_frame({s, 1'b0, 1'b0});
			check_outputs();
			finish_test($sformatf("random lights %0d", r));
		end

		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
